/* source/icache_pkg.sv */
package icache_pkg;

    // widths
    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = WORD_W * WORDS_PER_LINE;
    localparam int SETS           = 16;

    // address split, tag | index | word | byte
    localparam int BYTE_OFF_W = 2;
    localparam int WORD_OFF_W = 2;
    localparam int INDEX_W    = 4;
    localparam int TAG_W      = ADDR_W - INDEX_W - WORD_OFF_W - BYTE_OFF_W;

    // low bit of each address field
    localparam int WORD_OFF_LSB = BYTE_OFF_W;
    localparam int INDEX_LSB    = BYTE_OFF_W + WORD_OFF_W;
    localparam int TAG_LSB      = INDEX_LSB + INDEX_W;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [LINE_W-1:0]     line_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [WORD_OFF_W-1:0] word_off_t;

    typedef enum logic [1:0] {
        REFILL_IDLE,
        REFILL_ADDR,
        REFILL_DATA
    } refill_state_e;

    // one accepted read beat
    typedef struct packed {
        logic  valid;
        logic  last;
        word_t word;
    } r_beat_t;

    // completed line, valid is a one-cycle strobe
    typedef struct packed {
        logic   valid;
        index_t index;
        tag_t   tag;
        line_t  line;
    } line_fill_t;

endpackage

/* source/icache_tag.sv */
`timescale 1ns/10ps

module icache_tag (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req_valid_i,
    input  logic [icache_pkg::ADDR_W-1:0] req_addr_i,
    input  icache_pkg::line_fill_t        fill_i,
    output logic                          hit_o,
    output logic                          miss_o
);
    import icache_pkg::*;

    tag_t            tag_mem [SETS];
    logic [SETS-1:0] valid_q;

    index_t req_index;
    tag_t   req_tag;
    logic   tag_match;

    assign req_index = req_addr_i[INDEX_LSB +: INDEX_W];
    assign req_tag   = req_addr_i[TAG_LSB +: TAG_W];

    // direct mapped, one compare per lookup
    assign tag_match = valid_q[req_index] && (tag_mem[req_index] == req_tag);

    assign hit_o  = req_valid_i && tag_match;
    assign miss_o = req_valid_i && !tag_match;

    // valid bits start cleared so every set misses first
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill_i.valid) begin
            valid_q[fill_i.index] <= 1'b1;
        end
    end

    // tag written on the same edge as the line data
    always_ff @(posedge clk) begin
        if (fill_i.valid) begin
            tag_mem[fill_i.index] <= fill_i.tag;
        end
    end

endmodule

/* source/axi_refill.sv */
`timescale 1ns/10ps

module axi_refill (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          miss_i,
    input  logic [icache_pkg::ADDR_W-1:0] req_addr_i,
    // read address channel
    output logic                          ar_valid_o,
    output logic [icache_pkg::ADDR_W-1:0] ar_addr_o,
    input  logic                          ar_ready_i,
    // read data channel
    input  logic                          r_valid_i,
    input  icache_pkg::word_t             r_data_i,
    input  logic                          r_last_i,
    output logic                          r_ready_o,
    output icache_pkg::r_beat_t           beat_o
);
    import icache_pkg::*;

    refill_state_e state_q;
    refill_state_e state_d;
    logic          beat_fire;

    assign beat_fire = r_valid_i && r_ready_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            REFILL_IDLE: begin
                if (miss_i) begin
                    state_d = REFILL_ADDR;
                end
            end
            REFILL_ADDR: begin
                // wait for the slave to take the address
                if (ar_ready_i) begin
                    state_d = REFILL_DATA;
                end
            end
            REFILL_DATA: begin
                if (beat_fire && r_last_i) begin
                    state_d = REFILL_IDLE;
                end
            end
            default: begin
                state_d = REFILL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= REFILL_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // requester holds the address, so ar_addr_o stays put while waiting
    assign ar_valid_o = (state_q == REFILL_ADDR);
    assign ar_addr_o  = {req_addr_i[ADDR_W-1:INDEX_LSB], {INDEX_LSB{1'b0}}};
    assign r_ready_o  = (state_q == REFILL_DATA);

    // beats go out as they are accepted
    assign beat_o.valid = beat_fire;
    assign beat_o.last  = r_last_i;
    assign beat_o.word  = r_data_i;

endmodule

/* source/refill_buffer.sv */
`timescale 1ns/10ps

module refill_buffer (
    input  logic                          clk,
    input  logic                          rst,
    input  icache_pkg::r_beat_t           beat_i,
    input  logic [icache_pkg::ADDR_W-1:0] req_addr_i,
    output icache_pkg::line_fill_t        fill_o
);
    import icache_pkg::*;

    word_off_t beat_cnt;
    line_t     line_q;
    line_t     line_merged;

    // beats arrive in ascending word order
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
        end else if (beat_i.valid) begin
            beat_cnt <= beat_i.last ? '0 : beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_i.valid) begin
            line_q[beat_cnt*WORD_W +: WORD_W] <= beat_i.word;
        end
    end

    // last word bypasses the register so the fill is ready on that beat
    always_comb begin
        line_merged = line_q;
        line_merged[beat_cnt*WORD_W +: WORD_W] = beat_i.word;
    end

    assign fill_o.valid = beat_i.valid && beat_i.last;
    assign fill_o.index = req_addr_i[INDEX_LSB +: INDEX_W];
    assign fill_o.tag   = req_addr_i[TAG_LSB +: TAG_W];
    assign fill_o.line  = line_merged;

endmodule

/* source/icache_data.sv */
`timescale 1ns/10ps

module icache_data (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [icache_pkg::ADDR_W-1:0] req_addr_i,
    input  logic                          hit_i,
    input  icache_pkg::line_fill_t        fill_i,
    output logic                          resp_valid_o,
    output icache_pkg::word_t             resp_data_o
);
    import icache_pkg::*;

    line_t line_mem [SETS];

    index_t    req_index;
    word_off_t req_word;
    line_t     rd_line;
    word_t     rd_word;

    assign req_index = req_addr_i[INDEX_LSB +: INDEX_W];
    assign req_word  = req_addr_i[WORD_OFF_LSB +: WORD_OFF_W];

    // whole line written at once on the fill strobe
    always_ff @(posedge clk) begin
        if (fill_i.valid) begin
            line_mem[fill_i.index] <= fill_i.line;
        end
    end

    // word select within the indexed line
    assign rd_line = line_mem[req_index];
    assign rd_word = rd_line[req_word*WORD_W +: WORD_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid_o <= 1'b0;
        end else begin
            resp_valid_o <= hit_i;
        end
    end

    // data only loads on a hit, holds otherwise
    always_ff @(posedge clk) begin
        if (hit_i) begin
            resp_data_o <= rd_word;
        end
    end

endmodule

/* source/icache_top.sv */
`timescale 1ns/10ps

module icache_top (
    input  logic                          clk,
    input  logic                          rst,
    // requester side
    input  logic                          req_valid_i,
    input  logic [icache_pkg::ADDR_W-1:0] req_addr_i,
    output logic                          stall_o,
    output logic                          resp_valid_o,
    output icache_pkg::word_t             resp_data_o,
    // memory read address channel
    output logic                          ar_valid_o,
    output logic [icache_pkg::ADDR_W-1:0] ar_addr_o,
    input  logic                          ar_ready_i,
    // memory read data channel
    input  logic                          r_valid_i,
    input  icache_pkg::word_t             r_data_i,
    input  logic                          r_last_i,
    output logic                          r_ready_o
);
    import icache_pkg::*;

    logic       hit;
    r_beat_t    beat;
    line_fill_t fill;

    // miss level doubles as the requester stall
    icache_tag u_tag (
        .clk         (clk),
        .rst         (rst),
        .req_valid_i (req_valid_i),
        .req_addr_i  (req_addr_i),
        .fill_i      (fill),
        .hit_o       (hit),
        .miss_o      (stall_o)
    );

    axi_refill u_refill (
        .clk        (clk),
        .rst        (rst),
        .miss_i     (stall_o),
        .req_addr_i (req_addr_i),
        .ar_valid_o (ar_valid_o),
        .ar_addr_o  (ar_addr_o),
        .ar_ready_i (ar_ready_i),
        .r_valid_i  (r_valid_i),
        .r_data_i   (r_data_i),
        .r_last_i   (r_last_i),
        .r_ready_o  (r_ready_o),
        .beat_o     (beat)
    );

    refill_buffer u_buffer (
        .clk        (clk),
        .rst        (rst),
        .beat_i     (beat),
        .req_addr_i (req_addr_i),
        .fill_o     (fill)
    );

    icache_data u_data (
        .clk          (clk),
        .rst          (rst),
        .req_addr_i   (req_addr_i),
        .hit_i        (hit),
        .fill_i       (fill),
        .resp_valid_o (resp_valid_o),
        .resp_data_o  (resp_data_o)
    );

endmodule

/* test/icache_sva.sv */
`timescale 1ns/10ps

module icache_sva (
    input logic                          clk,
    input logic                          rst,
    input logic                          stall_i,
    input logic                          resp_valid_i,
    input logic                          ar_valid_i,
    input logic [icache_pkg::ADDR_W-1:0] ar_addr_i,
    input logic                          ar_ready_i,
    input logic                          r_ready_i
);
    import icache_pkg::*;

    // address held steady until the memory takes it
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i))
        else $error("ar_valid_o dropped or ar_addr_o moved before ar_ready_i");

    ar_align: assert property (@(posedge clk) disable iff (rst)
        ar_valid_i |-> ar_addr_i[INDEX_LSB-1:0] == '0)
        else $error("ar_addr_o is not line aligned");

    // a stalled request produces no response
    no_resp_after_stall: assert property (@(posedge clk) disable iff (rst)
        stall_i |=> !resp_valid_i)
        else $error("resp_valid_o high right after a stall cycle");

    ar_r_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(ar_valid_i && r_ready_i))
        else $error("ar_valid_o and r_ready_o high together");

endmodule

/* test/icache_tb.sv */
`timescale 1ns/10ps

module icache_tb;
    import icache_pkg::*;

    localparam int          MAX_CYCLES = 4000;
    localparam int          RAND_REQS  = 60;
    localparam logic [31:0] SEED       = 32'hac6c2c43;
    localparam logic [31:0] LINE_MASK  = WORDS_PER_LINE * 4 - 1;
    localparam logic [31:0] ADDR_A     = 32'h0000_0134;
    localparam logic [31:0] ADDR_B     = 32'h0000_0478;

    logic              clk        = 1'b0;
    logic              rst        = 1'b1;
    logic              req_valid  = 1'b0;
    logic [ADDR_W-1:0] req_addr   = '0;
    logic              ar_ready   = 1'b0;
    logic              r_valid    = 1'b0;
    word_t             r_data     = '0;
    logic              r_last     = 1'b0;
    logic              stall;
    logic              resp_valid;
    word_t             resp_data;
    logic              ar_valid;
    logic [ADDR_W-1:0] ar_addr;
    logic              r_ready;

    // memory model state
    logic              in_burst     = 1'b0;
    logic [1:0]        wait_cnt     = 2'd0;
    logic [1:0]        beat_idx     = 2'd0;
    logic [ADDR_W-1:0] last_ar_addr = '0;
    logic              rewritten    = 1'b0;
    logic [31:0]       delay_rng    = SEED;
    int                bursts_seen  = 0;
    int                errors       = 0;
    int                checks       = 0;
    int                cycles       = 0;

    icache_top dut0 (
        .clk(clk), .rst(rst),
        .req_valid_i(req_valid), .req_addr_i(req_addr), .stall_o(stall),
        .resp_valid_o(resp_valid), .resp_data_o(resp_data),
        .ar_valid_o(ar_valid), .ar_addr_o(ar_addr), .ar_ready_i(ar_ready),
        .r_valid_i(r_valid), .r_data_i(r_data), .r_last_i(r_last), .r_ready_o(r_ready)
    );

    bind icache_top icache_sva sva0 (
        .clk(clk), .rst(rst), .stall_i(stall_o), .resp_valid_i(resp_valid_o),
        .ar_valid_i(ar_valid_o), .ar_addr_i(ar_addr_o), .ar_ready_i(ar_ready_i),
        .r_ready_i(r_ready_o)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // memory contents before and after the rewrite
    function automatic word_t mem_word(input logic [ADDR_W-1:0] addr);
        return rewritten ? addr + 32'h1000 : addr ^ 32'h5a5a0000;
    endfunction

    // serves one burst at a time with 0 to 3 idle cycles before each handshake
    always @(posedge clk) begin
        delay_rng = xorshift(delay_rng);
        if (rst) begin
            in_burst <= 1'b0;
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
            wait_cnt <= 2'd0;
        end else if (!in_burst) begin
            if (ar_valid && ar_ready) begin
                ar_ready     <= 1'b0;
                in_burst     <= 1'b1;
                last_ar_addr <= ar_addr;
                bursts_seen  <= bursts_seen + 1;
                beat_idx     <= 2'd0;
                wait_cnt     <= delay_rng[1:0];
            end else if (ar_valid && wait_cnt == 2'd0) begin
                ar_ready <= 1'b1;
            end else if (ar_valid) begin
                wait_cnt <= wait_cnt - 1'b1;
            end else begin
                wait_cnt <= delay_rng[1:0];
            end
        end else if (r_valid && r_ready) begin
            r_valid  <= 1'b0;
            beat_idx <= beat_idx + 1'b1;
            wait_cnt <= delay_rng[1:0];
            in_burst <= !r_last;
        end else if (!r_valid && wait_cnt == 2'd0) begin
            r_valid <= 1'b1;
            r_last  <= (32'(beat_idx) == WORDS_PER_LINE - 1);
            r_data  <= mem_word(last_ar_addr + (32'(beat_idx) << 2));
        end else if (!r_valid) begin
            wait_cnt <= wait_cnt - 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, a request never completed", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic expect_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("Error at %0t: %s", $time, what);
            errors++;
        end
    endtask

    // one request that waits out the stall and checks the response word
    task automatic fetch(input logic [ADDR_W-1:0] addr, output int stalls, output int bursts);
        int start_bursts;
        start_bursts = bursts_seen;
        stalls = 0;
        req_valid <= 1'b1;
        req_addr  <= addr;
        @(posedge clk);
        while (stall) begin
            stalls++;
            @(posedge clk);
        end
        req_valid <= 1'b0;
        @(posedge clk);
        expect_equal("resp_valid_o", 32'(resp_valid), 32'd1);
        expect_equal("resp_data_o", resp_data, mem_word(addr));
        bursts = bursts_seen - start_bursts;
    endtask

    task automatic reset_and_first_miss();
        int stalls;
        int bursts;
        expect_equal("ar_valid_o", 32'(ar_valid), 32'd0);
        expect_equal("r_ready_o", 32'(r_ready), 32'd0);
        expect_equal("resp_valid_o", 32'(resp_valid), 32'd0);
        fetch(ADDR_A, stalls, bursts);
        expect_true(stalls > 0, "first request after reset did not raise stall_o");
    endtask

    task automatic cold_miss();
        int stalls;
        int bursts;
        fetch(ADDR_B, stalls, bursts);
        expect_true(stalls > 0, "cold miss did not stall");
        expect_equal("ar bursts", bursts, 1);
        expect_equal("ar_addr_o", last_ar_addr, ADDR_B & ~LINE_MASK);
    endtask

    task automatic hit_after_fill();
        int stalls;
        int bursts;
        fetch(ADDR_B, stalls, bursts);
        expect_equal("stall cycles", stalls, 0);
        expect_equal("ar bursts", bursts, 0);
    endtask

    task automatic back_to_back_hits(input logic [ADDR_W-1:0] line_addr);
        logic [ADDR_W-1:0] base;
        int                i;
        base = line_addr & ~LINE_MASK;
        req_valid <= 1'b1;
        req_addr  <= base;
        for (i = 0; i <= WORDS_PER_LINE; i++) begin
            @(posedge clk);
            if (i < WORDS_PER_LINE) begin
                expect_true(!stall, "back-to-back hit stalled");
            end
            if (i > 0) begin
                expect_equal("resp_valid_o", 32'(resp_valid), 32'd1);
                expect_equal("resp_data_o", resp_data, mem_word(base + 32'((i - 1) * 4)));
            end
            if (i < WORDS_PER_LINE - 1) begin
                req_addr <= base + 32'((i + 1) * 4);
            end else begin
                req_valid <= 1'b0;
            end
        end
    endtask

    // same index with the next tag up, then the evicted line comes back rewritten
    task automatic conflict_eviction();
        int stalls;
        int bursts;
        fetch(ADDR_B + 32'h100, stalls, bursts);
        expect_true(stalls > 0, "conflicting tag did not miss");
        expect_equal("ar bursts", bursts, 1);
        rewritten <= 1'b1;
        fetch(ADDR_B, stalls, bursts);
        expect_true(stalls > 0, "evicted line still hit");
        expect_equal("ar bursts", bursts, 1);
    endtask

    // direct-mapped model of which line each set holds
    task automatic random_requests();
        logic [31:0]       addr_rng;
        logic [ADDR_W-1:0] addr;
        logic [ADDR_W-1:0] held_line [SETS];
        logic [SETS-1:0]   held;
        logic              exp_miss;
        int                slot;
        int                stalls;
        int                bursts;
        int                n;
        addr_rng = SEED;
        held = '0;
        rewritten <= 1'b0;
        for (n = 0; n < RAND_REQS; n++) begin
            addr_rng = xorshift(addr_rng);
            // bit 16 keeps these tags apart from every earlier address
            addr = 32'h0001_0000 | (addr_rng & 32'h0000_0ffc);
            slot = int'(addr[INDEX_LSB +: INDEX_W]);
            exp_miss = !(held[slot] && held_line[slot] == (addr & ~LINE_MASK));
            fetch(addr, stalls, bursts);
            expect_equal("stall_o", 32'(stalls > 0), 32'(exp_miss));
            expect_equal("ar bursts", bursts, exp_miss ? 1 : 0);
            held[slot]      = 1'b1;
            held_line[slot] = addr & ~LINE_MASK;
        end
    endtask

    initial begin
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        reset_and_first_miss();
        cold_miss();
        hit_after_fill();
        back_to_back_hits(ADDR_B);
        conflict_eviction();
        random_requests();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* icache.f */
source/icache_pkg.sv
source/icache_tag.sv
source/axi_refill.sv
source/refill_buffer.sv
source/icache_data.sv
source/icache_top.sv
test/icache_sva.sv
test/icache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it and scan the log
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module icache_tb -f icache.f -o icache_sim
./obj_dir/icache_sim | tee sim.log

if grep -q "All checks passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
